// ==== vmul_pkg.sv ====
/*
 * Shared definitions for the vector integer multiply unit: element widths,
 * opcodes, instruction fields and the element and byte-enable helpers
 */
package vmul_pkg;

  localparam int unsigned ElenBits  = 64;
  localparam int unsigned StrbBits  = ElenBits / 8;
  localparam int unsigned NrVInsn   = 8;
  localparam int unsigned VLenBits  = 512;
  localparam int unsigned VRegWords = VLenBits / ElenBits;

  typedef logic [ElenBits-1:0]        elen_t;
  typedef logic [StrbBits-1:0]        strb_t;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [6:0]                 vlen_t;
  typedef logic [4:0]                 vreg_t;
  typedef logic [7:0]                 vaddr_t;

  // Element width code, also the index of the multiplier array
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef enum logic [2:0] {
    VMUL,
    VMULH,
    VMULHU,
    VMULHSU,
    VMACC,
    VNMSAC,
    VMADD,
    VNMSUB
  } mul_op_e;

  // Fields of one queued instruction
  typedef struct packed {
    vid_t    id;
    mul_op_e op;
    vew_e    vew;
    vlen_t   vl;
    vreg_t   vd;
    elen_t   scalar;
    logic    use_scalar;
    logic    use_vs1;
    logic    use_vs2;
    logic    use_vd;
  } insn_t;

  function automatic logic [3:0] elems_per_word(vew_e vew);
    return 4'd8 >> vew;
  endfunction

  // Low bytes covered by cnt elements of width vew
  function automatic strb_t byte_enable(logic [3:0] cnt, vew_e vew);
    logic [4:0]        nbytes;
    logic [StrbBits:0] ones;
    nbytes = 5'(cnt) << vew;
    ones   = ({{StrbBits{1'b0}}, 1'b1} << nbytes) - 1'b1;
    return ones[StrbBits-1:0];
  endfunction

endpackage

// ==== vmul_sequencer.sv ====
/*
 * Multiply sequencer. Holds the instruction queue, issues operand words to the
 * multiplier of the instruction's width and tracks processing and commit
 */
module vmul_sequencer import vmul_pkg::*; #(
  parameter int unsigned InsnQueueDepth = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Instruction input
  input  logic               insn_valid_i,
  output logic               insn_ready_o,
  input  vid_t               insn_id_i,
  input  mul_op_e            insn_op_i,
  input  vew_e               insn_vew_i,
  input  vlen_t              insn_vl_i,
  input  vreg_t              insn_vd_i,
  input  elen_t              insn_scalar_i,
  input  logic               insn_use_scalar_i,
  input  logic               insn_use_vs1_i,
  input  logic               insn_use_vs2_i,
  input  logic               insn_use_vd_i,
  // Operand queues: 0 is vs1, 1 is vs2, 2 is vd
  input  elen_t [2:0]        operand_i,
  input  logic  [2:0]        operand_valid_i,
  output logic  [2:0]        operand_ready_o,
  // Multipliers
  output logic  [3:0]        mul_valid_o,
  input  logic  [3:0]        mul_ready_i,
  output mul_op_e            mul_op_o,
  output elen_t              mul_a_o,
  output elen_t              mul_b_o,
  output elen_t              mul_c_o,
  // Writeback
  output logic               proc_valid_o,
  output vew_e               proc_vew_o,
  output vlen_t              proc_vl_o,
  output vreg_t              proc_vd_o,
  output vid_t               proc_id_o,
  input  logic               proc_done_i,
  input  logic               commit_beat_i,
  output logic [NrVInsn-1:0] vinsn_done_o
);

  localparam int unsigned PntBits = (InsnQueueDepth > 1) ? $clog2(InsnQueueDepth) : 1;

  typedef logic [PntBits-1:0] pnt_t;
  typedef logic [PntBits:0]   cnt_t;

  function automatic pnt_t next_pnt(pnt_t pnt);
    return (pnt == pnt_t'(InsnQueueDepth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  insn_t queue_q [InsnQueueDepth];
  insn_t insn_in, issue_insn, proc_insn, commit_insn;

  pnt_t accept_pnt_q, issue_pnt_q, proc_pnt_q, commit_pnt_q;
  cnt_t issue_cnt_q, proc_cnt_q, commit_cnt_q;

  // Elements already issued and committed for the head instructions
  vlen_t issued_q, committed_q;
  vlen_t issue_left, commit_left;
  logic [3:0] issue_epw, commit_epw;

  logic accept, issue_valid, operands_valid, issue_fire, issue_last, commit_last;
  elen_t scalar_rep;

  assign insn_in = '{
    id:         insn_id_i,
    op:         insn_op_i,
    vew:        insn_vew_i,
    vl:         insn_vl_i,
    vd:         insn_vd_i,
    scalar:     insn_scalar_i,
    use_scalar: insn_use_scalar_i,
    use_vs1:    insn_use_vs1_i,
    use_vs2:    insn_use_vs2_i,
    use_vd:     insn_use_vd_i
  };

  assign issue_insn  = queue_q[issue_pnt_q];
  assign proc_insn   = queue_q[proc_pnt_q];
  assign commit_insn = queue_q[commit_pnt_q];

  // An entry is freed only after its last write is granted
  assign insn_ready_o = (commit_cnt_q != cnt_t'(InsnQueueDepth));
  assign accept       = insn_valid_i & insn_ready_o;

  // Issue side
  assign issue_valid    = (issue_cnt_q != '0);
  assign operands_valid = (operand_valid_i[0] | ~issue_insn.use_vs1) &
                          (operand_valid_i[1] | ~issue_insn.use_vs2) &
                          (operand_valid_i[2] | ~issue_insn.use_vd);
  assign issue_fire     = issue_valid & operands_valid & mul_ready_i[issue_insn.vew];
  assign issue_epw      = elems_per_word(issue_insn.vew);
  assign issue_left     = issue_insn.vl - issued_q;
  assign issue_last     = (issue_left <= vlen_t'(issue_epw));

  always_comb begin
    mul_valid_o                 = '0;
    mul_valid_o[issue_insn.vew] = issue_valid & operands_valid;
  end

  assign operand_ready_o = issue_fire ? {issue_insn.use_vd, issue_insn.use_vs2,
                                         issue_insn.use_vs1} : 3'b000;

  // Scalar copied into every element of the word
  always_comb begin
    case (issue_insn.vew)
      EW8:     scalar_rep = {8{issue_insn.scalar[7:0]}};
      EW16:    scalar_rep = {4{issue_insn.scalar[15:0]}};
      EW32:    scalar_rep = {2{issue_insn.scalar[31:0]}};
      default: scalar_rep = issue_insn.scalar;
    endcase
  end

  assign mul_op_o = issue_insn.op;
  assign mul_a_o  = issue_insn.use_scalar ? scalar_rep : operand_i[0];
  assign mul_b_o  = operand_i[1];
  assign mul_c_o  = operand_i[2];

  assign proc_valid_o = (proc_cnt_q != '0);
  assign proc_vew_o   = proc_insn.vew;
  assign proc_vl_o    = proc_insn.vl;
  assign proc_vd_o    = proc_insn.vd;
  assign proc_id_o    = proc_insn.id;

  // Commit side, a beat never carries more than what is left
  assign commit_epw  = elems_per_word(commit_insn.vew);
  assign commit_left = commit_insn.vl - committed_q;
  assign commit_last = commit_beat_i & (commit_left <= vlen_t'(commit_epw));

  always_comb begin
    vinsn_done_o                 = '0;
    vinsn_done_o[commit_insn.id] = commit_last;
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      queue_q[accept_pnt_q] <= insn_in;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      proc_pnt_q   <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      proc_cnt_q   <= '0;
      commit_cnt_q <= '0;
      issued_q     <= '0;
      committed_q  <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= next_pnt(accept_pnt_q);
      end
      if (issue_fire) begin
        issued_q <= issue_last ? '0 : issued_q + vlen_t'(issue_epw);
        if (issue_last) begin
          issue_pnt_q <= next_pnt(issue_pnt_q);
        end
      end
      if (proc_done_i) begin
        proc_pnt_q <= next_pnt(proc_pnt_q);
      end
      if (commit_beat_i) begin
        committed_q <= commit_last ? '0 : committed_q + vlen_t'(commit_epw);
        if (commit_last) begin
          commit_pnt_q <= next_pnt(commit_pnt_q);
        end
      end
      issue_cnt_q  <= issue_cnt_q + cnt_t'(accept) - cnt_t'(issue_fire & issue_last);
      proc_cnt_q   <= proc_cnt_q + cnt_t'(accept) - cnt_t'(proc_done_i);
      commit_cnt_q <= commit_cnt_q + cnt_t'(accept) - cnt_t'(commit_last);
    end
  end

endmodule

// ==== vmul_simd_mul.sv ====
/*
 * SIMD integer multiplier for one element width, followed by a stall-able
 * pipeline of MulLatency registers
 */
module vmul_simd_mul import vmul_pkg::*; #(
  parameter vew_e        ElementWidth = EW64,
  parameter int unsigned MulLatency   = 2
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  mul_op_e op_i,
  input  elen_t   operand_a_i,
  input  elen_t   operand_b_i,
  input  elen_t   operand_c_i,
  input  logic    valid_i,
  output logic    ready_o,
  output elen_t   result_o,
  output logic    valid_o,
  input  logic    ready_i
);

  localparam int unsigned Ew      = 8 << ElementWidth;
  localparam int unsigned NrElems = ElenBits / Ew;

  elen_t                 result;
  elen_t                 data_q [MulLatency];
  logic [MulLatency-1:0] valid_q;
  logic                  advance;

  for (genvar e = 0; e < NrElems; e++) begin : gen_elem
    logic [Ew-1:0]          a, mult, addend, res;
    logic                   a_sgn, b_sgn, use_c;
    logic signed [2*Ew+1:0] prod;

    // VMADD and VNMSUB multiply by vd and add vs2
    assign use_c  = (op_i == VMADD) || (op_i == VNMSUB);
    assign a      = operand_a_i[e*Ew +: Ew];
    assign mult   = use_c ? operand_c_i[e*Ew +: Ew] : operand_b_i[e*Ew +: Ew];
    assign addend = use_c ? operand_b_i[e*Ew +: Ew] : operand_c_i[e*Ew +: Ew];
    assign a_sgn  = (op_i == VMULH);
    assign b_sgn  = (op_i == VMULH) || (op_i == VMULHSU);
    assign prod   = $signed({a_sgn & a[Ew-1], a}) * $signed({b_sgn & mult[Ew-1], mult});

    always_comb begin
      res = prod[Ew-1:0];
      case (op_i)
        VMULH, VMULHU, VMULHSU: res = prod[2*Ew-1:Ew];
        VMACC, VMADD:           res = addend + prod[Ew-1:0];
        VNMSAC, VNMSUB:         res = addend - prod[Ew-1:0];
        default:                res = prod[Ew-1:0];
      endcase
    end

    assign result[e*Ew +: Ew] = res;
  end

  // Whole pipeline moves unless the output word is stuck
  assign advance  = ready_i | ~valid_q[MulLatency-1];
  assign ready_o  = advance | ~valid_q[0];
  assign valid_o  = valid_q[MulLatency-1];
  assign result_o = data_q[MulLatency-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      if (ready_o) begin
        valid_q[0] <= valid_i;
      end
      for (int i = 1; i < MulLatency; i++) begin
        if (advance) begin
          valid_q[i] <= valid_q[i-1];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      data_q[0] <= result;
    end
    for (int i = 1; i < MulLatency; i++) begin
      if (advance) begin
        data_q[i] <= data_q[i-1];
      end
    end
  end

endmodule

// ==== vmul_writeback.sv ====
/*
 * Writeback stage. Drains the multiplier of the processing width, forms the
 * register file address and byte enables and queues words for the write port
 */
module vmul_writeback import vmul_pkg::*; #(
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  // Multipliers
  input  elen_t [3:0] mul_result_i,
  input  logic  [3:0] mul_valid_i,
  output logic  [3:0] mul_ready_o,
  // Processing instruction from the sequencer
  input  logic        proc_valid_i,
  input  vew_e        proc_vew_i,
  input  vlen_t       proc_vl_i,
  input  vreg_t       proc_vd_i,
  input  vid_t        proc_id_i,
  output logic        proc_done_o,
  output logic        commit_beat_o,
  // Register file write port
  output logic        result_req_o,
  output vid_t        result_id_o,
  output vaddr_t      result_addr_o,
  output elen_t       result_wdata_o,
  output strb_t       result_be_o,
  input  logic        result_gnt_i
);

  localparam int unsigned PntBits = (ResultQueueDepth > 1) ? $clog2(ResultQueueDepth) : 1;

  typedef logic [PntBits-1:0] pnt_t;
  typedef logic [PntBits:0]   cnt_t;

  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } payload_t;

  function automatic pnt_t next_pnt(pnt_t pnt);
    return (pnt == pnt_t'(ResultQueueDepth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  payload_t queue_q [ResultQueueDepth];
  payload_t entry;
  pnt_t     wr_pnt_q, rd_pnt_q;
  cnt_t     cnt_q;

  // Elements of the processing instruction already queued
  vlen_t      processed_q, left, word_idx;
  logic [3:0] epw, elem_cnt;
  logic       full, push, pop, last;

  assign full = (cnt_q == cnt_t'(ResultQueueDepth));

  always_comb begin
    mul_ready_o             = '0;
    mul_ready_o[proc_vew_i] = proc_valid_i & ~full;
  end

  assign push = proc_valid_i & mul_valid_i[proc_vew_i] & ~full;

  assign epw      = elems_per_word(proc_vew_i);
  assign left     = proc_vl_i - processed_q;
  assign last     = (left <= vlen_t'(epw));
  assign elem_cnt = last ? left[3:0] : epw;
  assign word_idx = processed_q >> ($clog2(StrbBits) - int'(proc_vew_i));

  assign entry.id    = proc_id_i;
  assign entry.addr  = vaddr_t'(proc_vd_i) * vaddr_t'(VRegWords) + vaddr_t'(word_idx);
  assign entry.wdata = mul_result_i[proc_vew_i];
  assign entry.be    = byte_enable(elem_cnt, proc_vew_i);

  assign proc_done_o = push & last;

  // Head of the queue waits on the port until granted
  assign result_req_o   = (cnt_q != '0);
  assign result_id_o    = queue_q[rd_pnt_q].id;
  assign result_addr_o  = queue_q[rd_pnt_q].addr;
  assign result_wdata_o = queue_q[rd_pnt_q].wdata;
  assign result_be_o    = queue_q[rd_pnt_q].be;

  assign pop           = result_req_o & result_gnt_i;
  assign commit_beat_o = pop;

  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[wr_pnt_q] <= entry;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q    <= '0;
      rd_pnt_q    <= '0;
      cnt_q       <= '0;
      processed_q <= '0;
    end else begin
      if (push) begin
        wr_pnt_q    <= next_pnt(wr_pnt_q);
        processed_q <= last ? '0 : processed_q + vlen_t'(epw);
      end
      if (pop) begin
        rd_pnt_q <= next_pnt(rd_pnt_q);
      end
      cnt_q <= cnt_q + cnt_t'(push) - cnt_t'(pop);
    end
  end

endmodule

// ==== vmul_unit.sv ====
/*
 * Vector integer multiply unit for one lane. Sequencer, one SIMD multiplier
 * per element width and the writeback stage with its result queue
 */
module vmul_unit import vmul_pkg::*; #(
  parameter int unsigned InsnQueueDepth   = 4,
  parameter int unsigned ResultQueueDepth = 2,
  parameter int unsigned MulLatency       = 2
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Instruction input
  input  logic               insn_valid_i,
  output logic               insn_ready_o,
  input  vid_t               insn_id_i,
  input  mul_op_e            insn_op_i,
  input  vew_e               insn_vew_i,
  input  vlen_t              insn_vl_i,
  input  vreg_t              insn_vd_i,
  input  elen_t              insn_scalar_i,
  input  logic               insn_use_scalar_i,
  input  logic               insn_use_vs1_i,
  input  logic               insn_use_vs2_i,
  input  logic               insn_use_vd_i,
  // Operand queues
  input  elen_t [2:0]        operand_i,
  input  logic  [2:0]        operand_valid_i,
  output logic  [2:0]        operand_ready_o,
  // Register file write port
  output logic               result_req_o,
  output vid_t               result_id_o,
  output vaddr_t             result_addr_o,
  output elen_t              result_wdata_o,
  output strb_t              result_be_o,
  input  logic               result_gnt_i,
  output logic [NrVInsn-1:0] vinsn_done_o
);

  logic  [3:0] mul_in_valid, mul_in_ready, mul_out_valid, mul_out_ready;
  elen_t [3:0] mul_result;
  mul_op_e     mul_op;
  elen_t       mul_a, mul_b, mul_c;

  logic  proc_valid, proc_done, commit_beat;
  vew_e  proc_vew;
  vlen_t proc_vl;
  vreg_t proc_vd;
  vid_t  proc_id;

  vmul_sequencer #(
    .InsnQueueDepth(InsnQueueDepth)
  ) sequencer_inst (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .insn_valid_i      (insn_valid_i),
    .insn_ready_o      (insn_ready_o),
    .insn_id_i         (insn_id_i),
    .insn_op_i         (insn_op_i),
    .insn_vew_i        (insn_vew_i),
    .insn_vl_i         (insn_vl_i),
    .insn_vd_i         (insn_vd_i),
    .insn_scalar_i     (insn_scalar_i),
    .insn_use_scalar_i (insn_use_scalar_i),
    .insn_use_vs1_i    (insn_use_vs1_i),
    .insn_use_vs2_i    (insn_use_vs2_i),
    .insn_use_vd_i     (insn_use_vd_i),
    .operand_i         (operand_i),
    .operand_valid_i   (operand_valid_i),
    .operand_ready_o   (operand_ready_o),
    .mul_valid_o       (mul_in_valid),
    .mul_ready_i       (mul_in_ready),
    .mul_op_o          (mul_op),
    .mul_a_o           (mul_a),
    .mul_b_o           (mul_b),
    .mul_c_o           (mul_c),
    .proc_valid_o      (proc_valid),
    .proc_vew_o        (proc_vew),
    .proc_vl_o         (proc_vl),
    .proc_vd_o         (proc_vd),
    .proc_id_o         (proc_id),
    .proc_done_i       (proc_done),
    .commit_beat_i     (commit_beat),
    .vinsn_done_o      (vinsn_done_o)
  );

  // Multiplier w serves element width vew_e'(w)
  for (genvar w = 0; w < 4; w++) begin : gen_mul
    vmul_simd_mul #(
      .ElementWidth(vew_e'(w)),
      .MulLatency  (MulLatency)
    ) mul_inst (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .op_i        (mul_op),
      .operand_a_i (mul_a),
      .operand_b_i (mul_b),
      .operand_c_i (mul_c),
      .valid_i     (mul_in_valid[w]),
      .ready_o     (mul_in_ready[w]),
      .result_o    (mul_result[w]),
      .valid_o     (mul_out_valid[w]),
      .ready_i     (mul_out_ready[w])
    );
  end

  vmul_writeback #(
    .ResultQueueDepth(ResultQueueDepth)
  ) writeback_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .mul_result_i   (mul_result),
    .mul_valid_i    (mul_out_valid),
    .mul_ready_o    (mul_out_ready),
    .proc_valid_i   (proc_valid),
    .proc_vew_i     (proc_vew),
    .proc_vl_i      (proc_vl),
    .proc_vd_i      (proc_vd),
    .proc_id_i      (proc_id),
    .proc_done_o    (proc_done),
    .commit_beat_o  (commit_beat),
    .result_req_o   (result_req_o),
    .result_id_o    (result_id_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i)
  );

endmodule

// ==== tb_vmul_unit.sv ====
/*
 * Testbench for the vector multiply unit. Feeds instructions and operand
 * words, models the expected register file writes and checks them in order
 */
module tb_vmul_unit import vmul_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ClkPeriod = 40;

  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  data;
    strb_t  be;
    logic   last;
  } exp_t;

  logic               clk_i, rst_ni, insn_valid_i, insn_ready_o;
  vid_t               insn_id_i, result_id_o;
  mul_op_e            insn_op_i;
  vew_e               insn_vew_i;
  vlen_t              insn_vl_i;
  vreg_t              insn_vd_i;
  elen_t              insn_scalar_i, result_wdata_o;
  logic               insn_use_scalar_i, insn_use_vs1_i, insn_use_vs2_i, insn_use_vd_i;
  elen_t [2:0]        operand_i;
  logic  [2:0]        operand_valid_i, operand_ready_o;
  logic               result_req_o, result_gnt_i;
  vaddr_t             result_addr_o;
  strb_t              result_be_o;
  logic [NrVInsn-1:0] vinsn_done_o;

  insn_t pending_q [$];
  elen_t vs1_q [$], vs2_q [$], vd_q [$];
  exp_t  exp_q [$];

  int    seed, gnt_mode, sent_total, accepted_total, done_total;
  int    test_errors, pass_tests, fail_tests;
  vid_t  next_id;
  string test_name;

  vmul_unit vmul_unit_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // Outputs are read late in the cycle, after the falling edge drive settled
  task automatic sample_point();
    @(negedge clk_i);
    #(ClkPeriod / 4);
  endtask

  task automatic check_value(string what, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s %s: expected %h actual %h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic report_error(string msg);
    $display("%s: %s", test_name, msg);
    test_errors++;
  endtask

  function automatic logic [127:0] sign_extend(logic [127:0] x, int ew);
    return x[ew-1] ? (x | ({128{1'b1}} << ew)) : x;
  endfunction

  // Expected word, element by element; a scalar operand sits in the low bits of a
  function automatic elen_t ref_word(mul_op_e op, vew_e vew, elen_t a, bit a_is_scalar,
                                     elen_t b, elen_t c);
    int           ew;
    logic [63:0]  mask;
    logic [127:0] ea, eb, ec, sa, sb, full;
    elen_t        res;
    ew   = 8 << vew;
    mask = (ew == 64) ? {64{1'b1}} : (64'd1 << ew) - 64'd1;
    res  = '0;
    for (int e = 0; e < 64 / ew; e++) begin
      ea = 128'((a_is_scalar ? a : a >> (e * ew)) & mask);
      eb = 128'((b >> (e * ew)) & mask);
      ec = 128'((c >> (e * ew)) & mask);
      sa = sign_extend(ea, ew);
      sb = sign_extend(eb, ew);
      case (op)
        VMUL:    full = ea * eb;
        VMULH:   full = (sa * sb) >> ew;
        VMULHU:  full = (ea * eb) >> ew;
        VMULHSU: full = (ea * sb) >> ew;
        VMACC:   full = ec + ea * eb;
        VNMSAC:  full = ec - ea * eb;
        VMADD:   full = eb + ea * ec;
        default: full = eb - ea * ec;
      endcase
      res = res | ((elen_t'(full) & mask) << (e * ew));
    end
    return res;
  endfunction

  // Edge words favour sign bits, all ones and the most negative values
  function automatic elen_t operand_word(bit edgy);
    elen_t w;
    w = {$random(seed), $random(seed)};
    if (edgy) begin
      case (w[2:0])
        3'd0:    w = 64'hFFFF_FFFF_FFFF_FFFF;
        3'd1:    w = 64'h8000_0000_0000_0000;
        3'd2:    w = 64'h7FFF_FFFF_FFFF_FFFF;
        3'd3:    w = 64'h80FF_7F01_80FF_7F01;
        default: w = w | 64'h8080_8080_8080_8080;
      endcase
    end
    return w;
  endfunction

  task automatic send_insn(mul_op_e op, vew_e vew, int vl, int vd, bit use_scalar, bit edgy);
    insn_t       insn;
    exp_t        exp;
    elen_t       a, b, c;
    int          epw, cnt;
    logic [15:0] be_bits;
    epw             = 8 >> vew;
    insn.id         = next_id;
    insn.op         = op;
    insn.vew        = vew;
    insn.vl         = vlen_t'(vl);
    insn.vd         = vreg_t'(vd);
    insn.scalar     = operand_word(edgy);
    insn.use_scalar = use_scalar;
    insn.use_vs1    = !use_scalar;
    insn.use_vs2    = 1'b1;
    insn.use_vd     = (op == VMACC) || (op == VNMSAC) || (op == VMADD) || (op == VNMSUB);
    pending_q.push_back(insn);
    for (int k = 0; k * epw < vl; k++) begin
      a = operand_word(edgy);
      b = operand_word(edgy);
      c = operand_word(edgy);
      if (!use_scalar) vs1_q.push_back(a);
      vs2_q.push_back(b);
      if (insn.use_vd) vd_q.push_back(c);
      cnt      = (vl - k * epw < epw) ? vl - k * epw : epw;
      be_bits  = (16'd1 << (cnt * (8 / epw))) - 16'd1;
      exp.id   = insn.id;
      exp.addr = vaddr_t'(vd * VRegWords + k);
      exp.data = ref_word(op, vew, use_scalar ? insn.scalar : a, use_scalar, b, c);
      exp.be   = strb_t'(be_bits);
      exp.last = ((k + 1) * epw >= vl);
      exp_q.push_back(exp);
    end
    next_id = vid_t'(next_id + 1);
    sent_total++;
  endtask

  task automatic start_test(string name);
    test_name   = name;
    test_errors = 0;
    sample_point();
  endtask

  task automatic end_test();
    while (done_total < sent_total) sample_point();
    if (exp_q.size() != 0) report_error("writes still expected after the last done pulse");
    $display("%-12s %s, %0d errors", test_name, (test_errors == 0) ? "ok" : "failed",
             test_errors);
    if (test_errors == 0) pass_tests++;
    else fail_tests++;
  endtask

  // Inputs change on the falling edge, handshakes are taken late in the cycle
  initial begin : drive
    forever begin
      @(negedge clk_i);
      insn_valid_i = (pending_q.size() != 0);
      if (pending_q.size() != 0) begin
        insn_id_i         = pending_q[0].id;
        insn_op_i         = pending_q[0].op;
        insn_vew_i        = pending_q[0].vew;
        insn_vl_i         = pending_q[0].vl;
        insn_vd_i         = pending_q[0].vd;
        insn_scalar_i     = pending_q[0].scalar;
        insn_use_scalar_i = pending_q[0].use_scalar;
        insn_use_vs1_i    = pending_q[0].use_vs1;
        insn_use_vs2_i    = pending_q[0].use_vs2;
        insn_use_vd_i     = pending_q[0].use_vd;
      end
      operand_valid_i = {vd_q.size() != 0, vs2_q.size() != 0, vs1_q.size() != 0};
      operand_i[0]    = (vs1_q.size() != 0) ? vs1_q[0] : '0;
      operand_i[1]    = (vs2_q.size() != 0) ? vs2_q[0] : '0;
      operand_i[2]    = (vd_q.size() != 0) ? vd_q[0] : '0;
      case (gnt_mode)
        1:       result_gnt_i = $random(seed) & 1;
        2:       result_gnt_i = 1'b0;
        default: result_gnt_i = 1'b1;
      endcase
      #(ClkPeriod / 4);
      if (insn_valid_i && insn_ready_o) begin
        void'(pending_q.pop_front());
        accepted_total++;
      end
      // An empty queue is offered as not valid, so ready there means an unused queue
      if (operand_ready_o[0]) begin
        if (vs1_q.size() == 0) report_error("vs1 ready pulsed with no vs1 word offered");
        else void'(vs1_q.pop_front());
      end
      if (operand_ready_o[1]) begin
        if (vs2_q.size() == 0) report_error("vs2 ready pulsed with no vs2 word offered");
        else void'(vs2_q.pop_front());
      end
      if (operand_ready_o[2]) begin
        if (vd_q.size() == 0) report_error("vd ready pulsed with no vd word offered");
        else void'(vd_q.pop_front());
      end
    end
  end

  initial begin : compare
    exp_t  exp;
    logic  held;
    exp_t  held_fields;
    held = 1'b0;
    forever begin
      sample_point();
      // A pending write must keep its fields until granted
      if (held) begin
        if (!result_req_o) report_error("write request dropped before its grant");
        check_value("held id", held_fields.id, result_id_o);
        check_value("held addr", held_fields.addr, result_addr_o);
        check_value("held data", held_fields.data, result_wdata_o);
        check_value("held be", held_fields.be, result_be_o);
      end
      held        = result_req_o && !result_gnt_i;
      held_fields = '{result_id_o, result_addr_o, result_wdata_o, result_be_o, 1'b0};
      if (result_req_o && result_gnt_i) begin
        if (exp_q.size() == 0) begin
          report_error("register file write with none expected");
        end else begin
          exp = exp_q.pop_front();
          check_value("data", exp.data, result_wdata_o);
          check_value("addr", exp.addr, result_addr_o);
          check_value("be", exp.be, result_be_o);
          check_value("id", exp.id, result_id_o);
          check_value("done", exp.last ? (64'd1 << exp.id) : 64'd0, vinsn_done_o);
        end
      end else if (vinsn_done_o != '0) begin
        report_error("done pulse without a granted write");
      end
      done_total += $countones(vinsn_done_o);
    end
  end

  // Budget of 200 cycles for every instruction sent so far
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < 200 * (sent_total + 1)) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: the unit stopped finishing instructions in test %s", test_name);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : main
    int base;
    seed = 81547;
    {gnt_mode, sent_total, accepted_total, done_total} = '0;
    {test_errors, pass_tests, fail_tests} = '0;
    next_id = '0;
    test_name = "reset";
    {insn_valid_i, insn_id_i, insn_vl_i, insn_vd_i, insn_scalar_i} = '0;
    {insn_use_scalar_i, insn_use_vs1_i, insn_use_vs2_i, insn_use_vd_i} = '0;
    insn_op_i       = VMUL;
    insn_vew_i      = EW8;
    operand_i       = '0;
    operand_valid_i = '0;
    result_gnt_i    = 1'b0;
    rst_ni          = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;

    start_test("reset");
    check_value("insn_ready_o", 1, insn_ready_o);
    check_value("operand_ready_o", 0, operand_ready_o);
    check_value("result_req_o", 0, result_req_o);
    check_value("vinsn_done_o", 0, vinsn_done_o);
    end_test();

    start_test("vmul_widths");
    send_insn(VMUL, EW8, 13, 2, 0, 0);
    send_insn(VMUL, EW16, 7, 5, 0, 0);
    send_insn(VMUL, EW32, 5, 9, 0, 0);
    send_insn(VMUL, EW64, 3, 31, 0, 0);
    end_test();

    start_test("scalar");
    send_insn(VMUL, EW8, 16, 1, 1, 0);
    send_insn(VMUL, EW16, 10, 3, 1, 1);
    send_insn(VMUL, EW32, 6, 4, 1, 0);
    send_insn(VMUL, EW64, 2, 6, 1, 1);
    send_insn(VMACC, EW32, 5, 7, 1, 0);
    end_test();

    start_test("mul_high");
    send_insn(VMULH, EW8, 16, 8, 0, 1);
    send_insn(VMULHU, EW8, 16, 9, 0, 1);
    send_insn(VMULHSU, EW8, 11, 10, 0, 1);
    send_insn(VMULH, EW64, 4, 11, 0, 1);
    send_insn(VMULHU, EW64, 4, 12, 0, 1);
    send_insn(VMULHSU, EW64, 3, 13, 0, 1);
    end_test();

    start_test("accumulate");
    send_insn(VMACC, EW8, 20, 14, 0, 1);
    send_insn(VNMSAC, EW16, 12, 15, 0, 0);
    send_insn(VMADD, EW32, 7, 16, 0, 1);
    send_insn(VNMSUB, EW64, 5, 17, 0, 0);
    end_test();

    start_test("backpressure");
    gnt_mode = 1;
    send_insn(VMUL, EW8, 64, 18, 0, 0);
    send_insn(VMACC, EW16, 32, 19, 0, 1);
    send_insn(VNMSUB, EW64, 8, 20, 0, 0);
    end_test();
    gnt_mode = 0;

    start_test("queue_full");
    gnt_mode = 2;
    base = accepted_total;
    for (int i = 0; i < 5; i++) send_insn(VMUL, EW16, 6, 21 + i, 0, 0);
    while (accepted_total != base + 4) sample_point();
    repeat (6) sample_point();
    check_value("accepted", base + 4, accepted_total);
    check_value("insn_ready_o", 0, insn_ready_o);
    gnt_mode = 0;
    end_test();

    $display("%0d tests passed, %0d tests failed", pass_tests, fail_tests);
    if (fail_tests == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== vmul_unit.f ====
vmul_pkg.sv
vmul_sequencer.sv
vmul_simd_mul.sv
vmul_writeback.sv
vmul_unit.sv
tb_vmul_unit.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_vmul_unit
FILELIST := vmul_unit.f
LOG      := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q -F "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
